// File: hw/mdecRegPkg.sv
package mdecRegPkg;

	// --------------------
	// Register map
	// --------------------
	localparam logic REG_DATA = 1'b0;	// Reg0: commands in, coefficients out
	localparam logic REG_CTRL = 1'b1;	// Reg1: control in, status out

	// Command codes, word bits 31:29
	localparam logic [2:0] CMD_STREAM = 3'd1;
	localparam logic [2:0] CMD_QUANT  = 3'd2;

	// Status word bit positions
	localparam int STAT_OUT_EMPTY = 31, STAT_IN_FULL = 30, STAT_BUSY = 29;
	localparam int STAT_IN_REQ    = 28;	// Data-in request
	localparam int STAT_OUT_REQ   = 27;	// Data-out request

	// Reg1 write bits
	localparam int CTRL_RESET = 31, CTRL_IN_EN = 30, CTRL_OUT_EN = 29;

	// Command sequencer state codes
	localparam logic [1:0] SEQ_IDLE  = 2'd0;	// Waiting for a command word
	localparam logic [1:0] SEQ_QUANT = 2'd1;	// Taking table words
	localparam logic [1:0] SEQ_HIGH  = 2'd2;	// Upper halfword out
	localparam logic [1:0] SEQ_LOW   = 2'd3;	// Lower halfword out

	// Input FIFO word, seen as a command or as table bytes
	typedef union packed {
		struct packed {
			logic [2:0]  code;		// Command
			logic [3:0]  setup;		// Output format bits, kept for status
			logic [8:0]  unused;
			logic [15:0] count;		// Parameter words that follow
		} cmd;
		logic [3:0][7:0] bytes;		// Byte 0 in bits 7:0
	} mdecWordT;

endpackage

// File: hw/mdecCorePkg.sv
package mdecCorePkg;

	// --------------------
	// FIFO sizing
	// --------------------
	localparam int FIFO_DEPTH = 32;			// Entries, power of two
	localparam int FIFO_AW    = 5;			// Pointer width
	localparam int FIFO_CW    = FIFO_AW + 1;	// Count reaches FIFO_DEPTH

	// --------------------
	// Quantization table
	// --------------------
	localparam int QUANT_WORDS = 16;		// Words per table load
	localparam int QUANT_BYTES = 64;		// One byte per coefficient

	// Stream decoding
	localparam logic [15:0] BLOCK_END = 16'hFE00;	// End-of-block halfword
	localparam int          COEF_MAX  = 32767;		// Saturation bound

endpackage

// File: hw/mdecFifo.sv
`timescale 1ns/1ps

module mdecFifo
	import mdecCorePkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_inValid,
	input  logic [31:0] i_inData,
	output logic        o_inReady,
	output logic        o_outValid,
	output logic [31:0] o_outData,
	input  logic        i_outReady,
	output logic        o_full,
	output logic        o_empty
);
	logic [31:0]        mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wrPtr;
	logic [FIFO_AW-1:0] rdPtr;
	logic [FIFO_CW-1:0] count;		// Words stored
	logic               push;
	logic               pop;

	assign o_full     = (count == FIFO_CW'(FIFO_DEPTH));
	assign o_empty    = (count == '0);
	assign o_inReady  = !o_full;
	assign o_outValid = !o_empty;
	assign o_outData  = mem[rdPtr];		// Head word, valid with o_outValid

	assign push = i_inValid && o_inReady;
	assign pop  = o_outValid && i_outReady;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;	// Wraps with the depth
			if (pop) rdPtr <= rdPtr + 1'b1;
			count <= count + FIFO_CW'(push) - FIFO_CW'(pop);
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) mem[wrPtr] <= i_inData;
	end

	// A push refused while full must be offered again, or the word is lost
	pushHeld: assert property (@(posedge i_clk) disable iff (i_reset)
		i_inValid && !o_inReady |=> i_inValid && $stable(i_inData));

endmodule

// File: hw/mdecCommandSequencer.sv
`timescale 1ns/1ps

module mdecCommandSequencer
	import mdecRegPkg::*;
	import mdecCorePkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	// Register port
	input  logic        i_regSelect,
	input  logic        i_write,
	input  logic [31:0] i_valueIn,
	output logic [31:0] o_valueOut,
	output logic        o_canWriteReg0,
	output logic        o_softReset,
	// Input FIFO side
	input  logic        i_fifoValid,
	input  mdecWordT    i_fifoData,
	input  logic        i_fifoFull,
	input  logic        i_fifoEmpty,
	output logic        o_fifoReady,
	// Dequantizer side
	output logic        o_halfValid,
	output logic [15:0] o_halfData,
	input  logic        i_halfReady,
	output logic        o_tableWrite,
	output logic [3:0]  o_tableAddr,
	output logic [31:0] o_tableData,
	input  logic        i_coreBusy,
	// Output FIFO head
	input  logic [31:0] i_outData,
	input  logic        i_outValid
);
	logic [1:0]  state;
	logic [1:0]  nextState;
	logic [3:0]  setupBits;		// From the last accepted command
	logic [15:0] remaining;		// Words still expected
	logic [15:0] quantIndex;
	logic        inEnable;
	logic        outEnable;
	logic        writeCtrl;
	logic        popWord;
	logic        lastWord;
	logic        countDown;
	logic [31:0] status;

	assign writeCtrl   = i_write && (i_regSelect == REG_CTRL);
	assign o_softReset = i_reset || (writeCtrl && i_valueIn[CTRL_RESET]);	// Also clears FIFOs
	assign popWord     = o_fifoReady && i_fifoValid;
	assign lastWord    = (remaining == 16'd1);
	assign quantIndex  = 16'(QUANT_WORDS) - remaining;	// 16 left -> word 0

	// --------------------
	// Command FSM
	// --------------------
	always_comb begin
		nextState   = state;
		o_fifoReady = 1'b0;
		o_halfValid = 1'b0;
		o_halfData  = i_fifoData[31:16];
		countDown   = 1'b0;
		case (state)
			SEQ_IDLE: begin
				o_fifoReady = 1'b1;		// Unknown words are dropped here
				if (i_fifoValid) begin
					if (i_fifoData.cmd.code == CMD_QUANT) begin
						nextState = SEQ_QUANT;
					end else if (i_fifoData.cmd.code == CMD_STREAM &&
							i_fifoData.cmd.count != 16'd0) begin
						nextState = SEQ_HIGH;
					end
				end
			end
			SEQ_QUANT: begin
				o_fifoReady = 1'b1;
				countDown   = i_fifoValid;
				if (i_fifoValid && lastWord) nextState = SEQ_IDLE;
			end
			SEQ_HIGH: begin
				o_halfValid = i_fifoValid;		// Word stays at FIFO head
				if (i_fifoValid && i_halfReady) nextState = SEQ_LOW;
			end
			SEQ_LOW: begin
				o_halfValid = i_fifoValid;
				o_halfData  = i_fifoData[15:0];
				o_fifoReady = i_halfReady;		// Pop once the low half is taken
				countDown   = popWord;
				if (popWord) nextState = lastWord ? SEQ_IDLE : SEQ_HIGH;
			end
			default: nextState = SEQ_IDLE;
		endcase
	end

	// Table words go straight through, one strobe per popped word
	assign o_tableWrite = (state == SEQ_QUANT) && i_fifoValid;
	assign o_tableAddr  = quantIndex[3:0];
	assign o_tableData  = i_fifoData.bytes;

	always_ff @(posedge i_clk) begin
		if (o_softReset) begin
			state     <= SEQ_IDLE;
			setupBits <= '0;
			remaining <= '0;		// Status shows FFFF
			inEnable  <= 1'b1;
			outEnable <= 1'b1;
		end else begin
			state <= nextState;
			if (state == SEQ_IDLE && popWord) begin
				if (i_fifoData.cmd.code == CMD_QUANT) begin
					remaining <= 16'(QUANT_WORDS);
					setupBits <= i_fifoData.cmd.setup;
				end else if (i_fifoData.cmd.code == CMD_STREAM) begin
					remaining <= i_fifoData.cmd.count;
					setupBits <= i_fifoData.cmd.setup;
				end
			end else if (countDown) begin
				remaining <= remaining - 16'd1;
			end
			if (writeCtrl) begin
				inEnable  <= i_valueIn[CTRL_IN_EN];
				outEnable <= i_valueIn[CTRL_OUT_EN];
			end
		end
	end

	// --------------------
	// Status and read mux
	// --------------------
	always_comb begin
		status                 = '0;
		status[STAT_OUT_EMPTY] = !i_outValid;
		status[STAT_IN_FULL]   = i_fifoFull;
		status[STAT_BUSY]      = (state != SEQ_IDLE) || i_coreBusy || !i_fifoEmpty;
		status[STAT_IN_REQ]    = !i_fifoFull && inEnable;
		status[STAT_OUT_REQ]   = i_outValid && outEnable;
		status[26:23]          = setupBits;
		status[15:0]           = remaining - 16'd1;	// Words left minus one
	end

	// Registered read, select of the previous cycle
	always_ff @(posedge i_clk) begin
		o_valueOut <= (i_regSelect == REG_CTRL) ? status : i_outData;
	end

	assign o_canWriteReg0 = !i_fifoFull;

	// Offered halfword may not change before the dequantizer takes it
	halfStable: assert property (@(posedge i_clk) disable iff (o_softReset)
		o_halfValid && !i_halfReady |=> o_halfValid && $stable(o_halfData));

endmodule

// File: hw/mdecRleDequant.sv
`timescale 1ns/1ps

module mdecRleDequant
	import mdecRegPkg::*;
	import mdecCorePkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_halfValid,
	input  logic [15:0] i_halfData,
	output logic        o_halfReady,
	input  logic        i_tableWrite,
	input  logic [3:0]  i_tableAddr,
	input  logic [31:0] i_tableData,
	output logic        o_outValid,
	output logic [31:0] o_outData,
	input  logic        i_outReady,
	output logic        o_busy
);
	logic [7:0]         quantTable [QUANT_BYTES];
	mdecWordT           tableWord;
	logic               inBlock;		// Low: next halfword is DC
	logic [6:0]         coefIndex;		// Extra bit catches overrun
	logic [6:0]         nextIndex;
	logic [5:0]         lookupIndex;
	logic               accept;
	logic               isEnd;
	logic               isDc;
	logic               produce;
	logic signed [9:0]  level;
	logic signed [18:0] product;
	logic signed [15:0] coef;

	// --------------------
	// Table memory
	// --------------------
	assign tableWord = i_tableData;

	always_ff @(posedge i_clk) begin
		if (i_tableWrite) begin
			for (int k = 0; k < 4; k++) begin
				quantTable[{i_tableAddr, 2'(k)}] <= tableWord.bytes[k];	// Four bytes per word
			end
		end
	end

	// --------------------
	// Run-length expansion
	// --------------------
	assign o_halfReady = !o_outValid || i_outReady;	// One-deep output stage
	assign accept      = i_halfValid && o_halfReady;
	assign isEnd       = (i_halfData == BLOCK_END);
	assign isDc        = !inBlock;
	assign level       = i_halfData[9:0];
	assign nextIndex   = coefIndex + {1'b0, i_halfData[15:10]} + 7'd1;	// Skip run zeros
	assign lookupIndex = isDc ? 6'd0 : nextIndex[5:0];
	assign produce     = accept && !isEnd && (isDc || !nextIndex[6]);	// Past 63 is dropped

	assign product = level * $signed({1'b0, quantTable[lookupIndex]});

	// Clamp to the 16-bit coefficient range
	always_comb begin
		if (product > COEF_MAX) coef = 16'(COEF_MAX);
		else if (product < -COEF_MAX) coef = 16'(-COEF_MAX);
		else coef = product[15:0];
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			inBlock    <= 1'b0;
			coefIndex  <= '0;
			o_outValid <= 1'b0;
		end else begin
			if (accept) begin
				if (isEnd) begin
					inBlock <= 1'b0;
				end else if (isDc) begin
					inBlock   <= 1'b1;
					coefIndex <= '0;
				end else if (!nextIndex[6]) begin
					coefIndex <= nextIndex;
				end
			end
			if (o_halfReady) o_outValid <= produce;	// Held while the FIFO is full
		end
	end

	always_ff @(posedge i_clk) begin
		if (produce) o_outData <= {10'd0, lookupIndex, coef};
	end

	assign o_busy = o_outValid;

	indexRange: assert property (@(posedge i_clk) disable iff (i_reset)
		coefIndex <= 7'd63);

endmodule

// File: hw/mdecTop.sv
`timescale 1ns/1ps

module mdecTop
	import mdecRegPkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_regSelect,
	input  logic        i_write,
	input  logic        i_read,
	input  logic [31:0] i_valueIn,
	output logic [31:0] o_valueOut,
	output logic        o_canWriteReg0
);
	logic        softReset;		// Hard reset or Reg1 bit 31
	logic        inPush;
	logic        outPop;
	logic        inFifoValid, inFifoReady, inFifoFull, inFifoEmpty;
	logic [31:0] inFifoData;
	logic        halfValid, halfReady;
	logic [15:0] halfData;
	logic        tableWrite;
	logic [3:0]  tableAddr;
	logic [31:0] tableData;
	logic        coefValid, coefReady, coreBusy;
	logic [31:0] coefData;
	logic        outFifoValid;
	logic [31:0] outFifoData;

	assign inPush = i_write && (i_regSelect == REG_DATA);
	assign outPop = i_read && (i_regSelect == REG_DATA);	// Pop as the word is latched

	// --------------------
	// Datapath
	// --------------------
	mdecFifo inFifo (
		.i_clk(i_clk), .i_reset(softReset),
		.i_inValid(inPush), .i_inData(i_valueIn), .o_inReady(),
		.o_outValid(inFifoValid), .o_outData(inFifoData), .i_outReady(inFifoReady),
		.o_full(inFifoFull), .o_empty(inFifoEmpty)
	);

	mdecCommandSequencer sequencer (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_regSelect(i_regSelect), .i_write(i_write), .i_valueIn(i_valueIn),
		.o_valueOut(o_valueOut), .o_canWriteReg0(o_canWriteReg0), .o_softReset(softReset),
		.i_fifoValid(inFifoValid), .i_fifoData(inFifoData), .i_fifoFull(inFifoFull),
		.i_fifoEmpty(inFifoEmpty), .o_fifoReady(inFifoReady),
		.o_halfValid(halfValid), .o_halfData(halfData), .i_halfReady(halfReady),
		.o_tableWrite(tableWrite), .o_tableAddr(tableAddr), .o_tableData(tableData),
		.i_coreBusy(coreBusy), .i_outData(outFifoData), .i_outValid(outFifoValid)
	);

	mdecRleDequant dequant (
		.i_clk(i_clk), .i_reset(softReset),
		.i_halfValid(halfValid), .i_halfData(halfData), .o_halfReady(halfReady),
		.i_tableWrite(tableWrite), .i_tableAddr(tableAddr), .i_tableData(tableData),
		.o_outValid(coefValid), .o_outData(coefData), .i_outReady(coefReady),
		.o_busy(coreBusy)
	);

	mdecFifo outFifo (
		.i_clk(i_clk), .i_reset(softReset),
		.i_inValid(coefValid), .i_inData(coefData), .o_inReady(coefReady),	// Back-pressure
		.o_outValid(outFifoValid), .o_outData(outFifoData), .i_outReady(outPop),
		.o_full(), .o_empty()
	);

endmodule

// File: bench/mdecTbClock.sv
`timescale 1ns/1ps

module mdecTbClock (
	output logic o_clk,
	output logic o_reset
);
	// 20 ns period
	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = !o_clk;
	end

	// Two rising edges in reset, released on a falling edge
	initial begin
		o_reset = 1'b1;
		repeat (2) @(posedge o_clk);
		@(negedge o_clk);
		o_reset = 1'b0;
	end

endmodule

// File: bench/mdecTb.sv
`timescale 1ns/1ps

module mdecTb
	import mdecRegPkg::*;
();
	localparam string TEST_FILE = "bench/mdecTests.txt";

	logic        clk;
	logic        reset;
	logic        regSelect;
	logic        write;
	logic        read;
	logic [31:0] valueIn;
	logic [31:0] valueOut;
	logic        canWriteReg0;

	logic [15:0] lfsr;				// Read gap source
	int          cycleCount = 0;
	int          cycleLimit = 0;		// Set once the file is sized
	string       testName;

	mdecTbClock clockGen (.o_clk(clk), .o_reset(reset));

	mdecTop dut (
		.i_clk(clk),
		.i_reset(reset),
		.i_regSelect(regSelect),
		.i_write(write),
		.i_read(read),
		.i_valueIn(valueIn),
		.o_valueOut(valueOut),
		.o_canWriteReg0(canWriteReg0)
	);

	// --------------------
	// Helpers
	// --------------------
	// Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		lfsrNext = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic abortRun(input string reason);
		if (reason.len() > 0) $display("%0s", reason);
		$display("Finished with errors");
		$fatal(1, "Run stopped after a failure");
	endtask

	task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %0s: expected %08h, actual %08h", testName, expected, actual);
			abortRun("");
		end
	endtask

	// 0 to 3 idle cycles, one LFSR step per bit
	task automatic idleBeforeRead();
		int gap;
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			gap = gap | (int'(lfsr[0]) << b);
			lfsr = lfsrNext(lfsr);
		end
		repeat (gap) @(negedge clk);
	endtask

	// Entered and left on a falling edge
	task automatic writeReg(input logic sel, input logic [31:0] value);
		while (sel == REG_DATA && !canWriteReg0) @(negedge clk);	// Input FIFO full
		regSelect = sel;
		valueIn   = value;
		write     = 1'b1;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic readReg(input logic sel, output logic [31:0] value);
		regSelect = sel;
		read      = (sel == REG_DATA);	// Reg0 read pops the output FIFO
		@(negedge clk);
		read  = 1'b0;
		value = valueOut;				// Latched on the rising edge between
	endtask

	// Poll status until one bit reads 0
	task automatic waitStatusClear(input int bitPos);
		logic [31:0] status;
		readReg(REG_CTRL, status);
		while (status[bitPos]) readReg(REG_CTRL, status);
	endtask

	// --------------------
	// Timeout
	// --------------------
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			abortRun($sformatf("Run timed out after %0d cycles", cycleCount));
		end
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		int          fd;
		int          lineCount;
		int          fields;
		string       line;
		string       op;
		logic [31:0] value;
		logic [31:0] actual;
		logic        canWrite;

		regSelect  = REG_CTRL;
		write      = 1'b0;
		read       = 1'b0;
		valueIn    = '0;
		lfsr       = 16'd15357;
		testName   = "setup";

		// Size the timeout from the file length
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) abortRun({"Cannot open the test file ", TEST_FILE});
		lineCount = 0;
		while ($fgets(line, fd) != 0) lineCount++;
		$fclose(fd);
		cycleLimit = 64 * lineCount;

		fd = $fopen(TEST_FILE, "r");
		wait (!reset);
		@(negedge clk);
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") continue;	// Blank or comment
			fields = $sscanf(line, "%s %s %h", op, testName, value);
			if (fields != 3) abortRun({"Test file line is malformed: ", line});
			if (op == "W0") begin
				writeReg(REG_DATA, value);
			end else if (op == "W1") begin
				writeReg(REG_CTRL, value);
			end else if (op == "WB") begin
				waitStatusClear(STAT_BUSY);
			end else if (op == "ID") begin
				repeat (value) @(negedge clk);
			end else if (op == "R0") begin
				waitStatusClear(STAT_OUT_EMPTY);	// Coefficient must be there
				idleBeforeRead();
				readReg(REG_DATA, actual);
				checkValue(value, actual);
			end else if (op == "R1") begin
				idleBeforeRead();
				canWrite = canWriteReg0;		// Same edge as the status sample
				readReg(REG_CTRL, actual);
				checkValue(value, actual);
				checkValue(32'(!value[STAT_IN_FULL]), 32'(canWrite));	// Low only when input full
			end else begin
				abortRun({"Test file has an unknown operation: ", op});
			end
		end
		$fclose(fd);

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: bench/mdecTests.txt
# op name hexValue: W0/W1 write reg, R0/R1 read reg and expect value
# WB waits until status not busy (value unused), ID idles for value cycles
R1 resetStatus 9000FFFF
W0 quantCmd 40000000
W0 quant00 0F0B0703
W0 quant01 1F1B1713
W0 quant02 2F2B2723
W0 quant03 3F3B3733
W0 quant04 4F4B4743
W0 quant05 5F5B5753
W0 quant06 6F6B6763
W0 quant07 7F7B7773
W0 quant08 8F8B8783
W0 quant09 9F9B9793
W0 quant10 AFABA7A3
W0 quant11 BFBBB7B3
W0 quant12 CFCBC7C3
W0 quant13 DFDBD7D3
W0 quant14 EFEBE7E3
W0 quant15 FFFBF7F3
W0 runCmd 2A000004
W0 runWord0 000A0005
W0 runWord1 0BFC2DFF
W0 runWord2 0200FE00
W0 runWord3 03FDF801
WB runDrain 0
R1 runStatus 1A80FFFF
W1 requestsOff 00000000
R1 requestsOffStatus 0280FFFF
R0 runDcIdx0 0000001E
R0 runAcIdx1 00010023
R0 runAcIdx4 0004FFB4
R0 satPosIdx16 00107FFF
R0 satNegIdx17 00118001
R0 newBlockDc 0000FFF7
R0 lastAcIdx63 003F00FF
W1 requestsOn 60000000
W0 fillCmd 38000012
W0 fillWord00 FE000001
W0 fillWord01 00010001
W0 fillWord02 00010001
W0 fillWord03 00010001
W0 fillWord04 00010001
W0 fillWord05 00010001
W0 fillWord06 00010001
W0 fillWord07 00010001
W0 fillWord08 00010001
W0 fillWord09 00010001
W0 fillWord10 00010001
W0 fillWord11 00010001
W0 fillWord12 00010001
W0 fillWord13 00010001
W0 fillWord14 00010001
W0 fillWord15 00010001
W0 fillWord16 00010001
W0 fillWord17 00010001
ID fillSettle 30
R1 stalledStatus 3E000000
R0 fillCoef00 00000003
R0 fillCoef01 00010007
R0 fillCoef02 0002000B
R0 fillCoef03 0003000F
R0 fillCoef04 00040013
R0 fillCoef05 00050017
R0 fillCoef06 0006001B
R0 fillCoef07 0007001F
R0 fillCoef08 00080023
R0 fillCoef09 00090027
R0 fillCoef10 000A002B
R0 fillCoef11 000B002F
R0 fillCoef12 000C0033
R0 fillCoef13 000D0037
R0 fillCoef14 000E003B
R0 fillCoef15 000F003F
R0 fillCoef16 00100043
R0 fillCoef17 00110047
R0 fillCoef18 0012004B
R0 fillCoef19 0013004F
R0 fillCoef20 00140053
R0 fillCoef21 00150057
R0 fillCoef22 0016005B
R0 fillCoef23 0017005F
R0 fillCoef24 00180063
R0 fillCoef25 00190067
R0 fillCoef26 001A006B
R0 fillCoef27 001B006F
R0 fillCoef28 001C0073
R0 fillCoef29 001D0077
R0 fillCoef30 001E007B
R0 fillCoef31 001F007F
R0 fillCoef32 00200083
R0 fillCoef33 00210087
R0 fillCoef34 0022008B
WB fillDrain 0
R1 setupStatus 9600FFFF
W0 partCmd 20000004
W0 partWord0 00050006
W0 partWord1 00070008
W1 softReset 80000000
R1 softResetStatus 9000FFFF

// File: sim.f
hw/mdecRegPkg.sv
hw/mdecCorePkg.sv
hw/mdecFifo.sv
hw/mdecCommandSequencer.sv
hw/mdecRleDequant.sv
hw/mdecTop.sv
bench/mdecTbClock.sv
bench/mdecTb.sv

// File: Makefile
TOP = mdecTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
